// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Mdir obj_dir
TOP      = tb_top
FILELIST = sim.f
LOG      = sim.log
PASS_MSG = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic aclk,
	output logic rst_o
);

	initial begin
		aclk = 1'b0;
		forever #(PERIOD_NS / 2) aclk = ~aclk;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge aclk);
		#1 rst_o = 1'b0;
	end

endmodule

// ==== bench/tb_phy_model.sv ====
`timescale 1ns/1ps

module tb_phy_model (
	input  logic                   mdc_i,
	input  logic                   mdio_i,
	input  logic                   mdio_oe_i,
	output logic                   mdio_o,
	output e1000_pkg::mdio_frame_t last_frame_o,
	output logic [31:0]            last_oe_o,
	output int                     frame_cnt_o,
	output int                     mdc_edges_o
);

	e1000_pkg::mdio_data_t  regs [32];
	e1000_pkg::mdio_frame_t cur;
	logic [31:0]            oe_cur;
	e1000_pkg::reg_addr_t   rd_addr;
	int                     ones_cnt = 0;
	int                     fbit = -1; // Next frame bit or -1 in the preamble hunt
	logic                   reading = 1'b0;
	logic                   drive_q = 1'b1;

	// Pull-up when the DUT releases the line
	assign mdio_o = (mdio_oe_i === 1'b1) ? mdio_i : drive_q;

	task automatic sample_bit();
		mdc_edges_o = mdc_edges_o + 1;
		if (fbit < 0) begin
			if (mdio_o === 1'b1) begin
				ones_cnt = ones_cnt + 1;
			end else begin
				if (ones_cnt >= e1000_pkg::PREAMBLE_BITS) begin
					cur        = '0; // Start bit 0 is frame bit 0
					oe_cur     = '0;
					oe_cur[31] = (mdio_oe_i === 1'b1);
					fbit       = 1;
				end
				ones_cnt = 0;
			end
		end else begin
			cur[31 - fbit]    = mdio_o;
			oe_cur[31 - fbit] = (mdio_oe_i === 1'b1);
			fbit = fbit + 1;
			if (fbit == 14 && cur[29:28] == 2'b10) begin
				reading = 1'b1;
				rd_addr = cur[22:18];
			end
			if (fbit == 32) begin
				last_frame_o = cur;
				last_oe_o    = oe_cur;
				frame_cnt_o  = frame_cnt_o + 1;
				if (cur[29:28] == 2'b01)
					regs[cur[22:18]] = cur[15:0];
				reading = 1'b0;
				fbit    = -1;
			end
		end
	endtask

	// PHY output changes while MDC is low
	task automatic drive_next();
		if (reading && fbit >= 16)
			drive_q = regs[rd_addr][31 - fbit];
		else if (reading && fbit == 15)
			drive_q = 1'b0;
		else
			drive_q = 1'b1;
	endtask

	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = 16'hA500 + 16'(i);
		last_frame_o = '0;
		last_oe_o    = '0;
		frame_cnt_o  = 0;
		mdc_edges_o  = 0;
		forever begin
			@(mdc_i);
			if (mdc_i === 1'b1)
				sample_bit();
			else
				drive_next();
		end
	end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	localparam int CLK_NS      = 10;
	localparam int BIT_CYCLES  = 10; // 2 x MDC_DIV aclk cycles per MDIO bit
	localparam int MAX_GNT     = 64;
	localparam int NUM_TRANS   = 6;
	localparam int POLL_LIMIT  = 32;
	localparam int WATCHDOG_NS = NUM_TRANS * (64 * BIT_CYCLES + MAX_GNT) * 2 * CLK_NS;
	localparam e1000_pkg::phy_addr_t PHY_ADDR = 5'h01;
	localparam logic [31:0] MDIC   = e1000_pkg::MDIC_OFFSET;
	localparam logic [31:0] R_MASK = 32'h1 << e1000_pkg::MDIC_R_BIT;
	localparam logic [31:0] E_MASK = 32'h1 << e1000_pkg::MDIC_E_BIT;

	logic                   aclk;
	logic                   rst;
	logic                   reg_wr;
	logic                   reg_rd;
	logic [31:0]            reg_addr;
	logic [31:0]            reg_wdata;
	logic [31:0]            reg_rdata;
	logic                   intr;
	logic                   mdc;
	logic                   mdio_in;
	logic                   mdio_out;
	logic                   mdio_oe;
	logic                   mdio_req;
	logic                   gnt;
	e1000_pkg::mdio_frame_t last_frame;
	logic [31:0]            last_oe;
	int                     frame_cnt;
	int                     mdc_edges;
	integer                 seed = 32'h4fe7_5d4c;

	tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clkgen (
		.aclk  (aclk),
		.rst_o (rst)
	);

	tb_phy_model u_phy_model (
		.mdc_i        (mdc),
		.mdio_i       (mdio_out),
		.mdio_oe_i    (mdio_oe),
		.mdio_o       (mdio_in),
		.last_frame_o (last_frame),
		.last_oe_o    (last_oe),
		.frame_cnt_o  (frame_cnt),
		.mdc_edges_o  (mdc_edges)
	);

	e1000_mdio_top #(
		.CLK_PERIOD_NS (CLK_NS),
		.MDIO_FREQ     (25000000),
		.PHY_ADDR      (PHY_ADDR)
	) u_e1000_mdio_top (
		.aclk           (aclk),
		.rst_i          (rst),
		.reg_wr_i       (reg_wr),
		.reg_rd_i       (reg_rd),
		.reg_addr_i     (reg_addr),
		.reg_wdata_i    (reg_wdata),
		.reg_rdata_o    (reg_rdata),
		.intr_o         (intr),
		.phy_mdc_o      (mdc),
		.phy_mdio_i     (mdio_in),
		.phy_mdio_o     (mdio_out),
		.phy_mdio_oe_o  (mdio_oe),
		.phy_mdio_req_o (mdio_req),
		.phy_mdio_gnt_i (gnt)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_data(input string name, input e1000_pkg::mdio_data_t got,
		input e1000_pkg::mdio_data_t exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_frame(input string name, input e1000_pkg::mdio_frame_t got,
		input e1000_pkg::mdio_frame_t exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	// Clause 22 frame with ST 01, OP, PHYAD, REGAD, TA 10 and DATA from the MSB down
	function automatic e1000_pkg::mdio_frame_t expect_frame(input logic [1:0] op,
		input e1000_pkg::reg_addr_t regad, input e1000_pkg::mdio_data_t data);
		return {2'b01, op, PHY_ADDR, regad, 2'b10, data};
	endfunction

	function automatic logic [31:0] mdic_cmd(input logic [1:0] op, input logic irq,
		input e1000_pkg::reg_addr_t regad, input e1000_pkg::mdio_data_t data);
		logic [31:0] w;
		w = '0;
		w[e1000_pkg::MDIC_DATA_LSB +: 16] = data;
		w[e1000_pkg::MDIC_REGAD_LSB +: 5] = regad;
		w[e1000_pkg::MDIC_PHYAD_LSB +: 5] = 5'h1e; // Not used on the wire
		w[e1000_pkg::MDIC_OP_LSB +: 2]    = op;
		w[e1000_pkg::MDIC_I_BIT]          = irq;
		return w;
	endfunction

	function automatic int grant_delay();
		return $unsigned($random(seed)) % MAX_GNT;
	endfunction

	task automatic step();
		@(posedge aclk);
		#1;
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		step();
		reg_wr = 1'b0;
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] v);
		reg_rd   = 1'b1;
		reg_addr = addr;
		step();
		reg_rd = 1'b0;
		v      = reg_rdata;
	endtask

	task automatic issue_cmd(input logic [31:0] cmd);
		logic [31:0] v;
		write_reg(MDIC, cmd);
		read_reg(MDIC, v);
		check_bit("mdic ready bit", v[e1000_pkg::MDIC_R_BIT], 1'b0);
	endtask

	task automatic poll_ready(output logic [31:0] v);
		int n;
		n = 0;
		read_reg(MDIC, v);
		while (v[e1000_pkg::MDIC_R_BIT] !== 1'b1) begin
			if (n == POLL_LIMIT)
				abort_run("MDIC ready bit never set after the command");
			read_reg(MDIC, v);
			n++;
		end
	endtask

	// MDC must stay quiet while the grant is held off
	task automatic grant_bus(input int delay);
		int n;
		n = 0;
		while (mdio_req !== 1'b1) begin
			if (n == MAX_GNT)
				abort_run("Bus request was never raised");
			step();
			n++;
		end
		repeat (delay) begin
			check_bit("phy_mdio_req_o", mdio_req, 1'b1);
			check_bit("phy_mdc_o", mdc, 1'b0);
			step();
		end
		gnt = 1'b1;
		n   = 0;
		while (mdio_req === 1'b1) begin
			if (n == 64 * BIT_CYCLES + 8)
				abort_run("Bus request did not drop after the frame");
			step();
			n++;
		end
		gnt = 1'b0;
	endtask

	task automatic reset_values();
		logic [31:0] v;
		read_reg(MDIC, v);
		check_word("mdic", v, 32'h0);
		check_bit("intr_o", intr, 1'b0);
		check_bit("phy_mdc_o", mdc, 1'b0);
		check_bit("phy_mdio_oe_o", mdio_oe, 1'b0);
		check_bit("phy_mdio_req_o", mdio_req, 1'b0);
		check_bit("phy_mdio_o", mdio_out, 1'b1);
	endtask

	task automatic write_transaction(input e1000_pkg::reg_addr_t regad,
		input e1000_pkg::mdio_data_t data);
		logic [31:0] cmd;
		logic [31:0] v;
		int          edges;
		cmd   = mdic_cmd(2'b01, 1'b0, regad, data);
		edges = mdc_edges;
		issue_cmd(cmd);
		grant_bus(grant_delay());
		poll_ready(v);
		check_frame("phy frame", last_frame, expect_frame(2'b01, regad, data));
		check_word("phy_mdio_oe_o per frame bit", last_oe, 32'hFFFF_FFFF);
		check_word("mdc edge count", mdc_edges - edges, 64);
		check_word("mdic", v, cmd | R_MASK);
		check_data("phy reg", u_phy_model.regs[regad], data);
		check_bit("intr_o", intr, 1'b0);
		read_reg(MDIC + 32'h4, v); // Unmapped address
		check_word("unmapped read", v, 32'h0);
	endtask

	task automatic read_transaction(input e1000_pkg::reg_addr_t regad,
		input e1000_pkg::mdio_data_t exp);
		logic [31:0] v;
		int          edges;
		edges = mdc_edges;
		issue_cmd(mdic_cmd(2'b10, 1'b0, regad, 16'h0));
		grant_bus(grant_delay());
		poll_ready(v);
		// TA and data on the wire come from the PHY
		check_frame("phy frame", last_frame, expect_frame(2'b10, regad, exp));
		check_word("phy_mdio_oe_o per frame bit", last_oe, 32'hFFFC_0000); // Released from bit 14
		check_word("mdc edge count", mdc_edges - edges, 64);
		check_word("mdic", v, mdic_cmd(2'b10, 1'b0, regad, exp) | R_MASK);
	endtask

	task automatic illegal_opcode();
		logic [31:0] cmd;
		logic [31:0] v;
		int          edges;
		cmd   = mdic_cmd(2'b11, 1'b0, 5'h03, 16'hBEEF);
		edges = mdc_edges;
		issue_cmd(cmd);
		repeat (4) begin
			check_bit("phy_mdio_req_o", mdio_req, 1'b0);
			step();
		end
		poll_ready(v);
		check_word("mdic", v, cmd | R_MASK | E_MASK);
		check_bit("phy_mdio_req_o", mdio_req, 1'b0);
		check_word("mdc edge count", mdc_edges - edges, 0);
	endtask

	task automatic interrupt_completion();
		logic [31:0] cmd;
		logic [31:0] v;
		int          n;
		cmd = mdic_cmd(2'b01, 1'b1, 5'h07, 16'h5A5A);
		issue_cmd(cmd);
		check_bit("intr_o", intr, 1'b0);
		grant_bus(8 + grant_delay() % 56);
		n = 0;
		while (intr !== 1'b1) begin
			if (n == 16)
				abort_run("Interrupt was not raised at completion");
			step();
			n++;
		end
		read_reg(MDIC, v);
		check_word("mdic", v, cmd | R_MASK);
		check_bit("intr_o", intr, 1'b0);
		check_data("phy reg", u_phy_model.regs[7], 16'h5A5A);
	endtask

	task automatic write_while_busy();
		logic [31:0] first;
		logic [31:0] v;
		int          frames;
		first  = mdic_cmd(2'b01, 1'b0, 5'h0A, 16'hC3C3);
		frames = frame_cnt;
		issue_cmd(first);
		write_reg(MDIC, mdic_cmd(2'b01, 1'b1, 5'h0B, 16'h0F0F));
		read_reg(MDIC, v);
		check_word("mdic while busy", v, first);
		grant_bus(grant_delay());
		poll_ready(v);
		check_frame("phy frame", last_frame, expect_frame(2'b01, 5'h0A, 16'hC3C3));
		check_word("mdic", v, first | R_MASK);
		repeat (20) begin
			check_bit("phy_mdio_req_o", mdio_req, 1'b0);
			step();
		end
		check_word("frame count", frame_cnt - frames, 1);
		check_data("phy reg", u_phy_model.regs[11], 16'hA50B);
		check_bit("intr_o", intr, 1'b0);
	endtask

	initial begin
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;
		gnt       = 1'b0;
		wait (rst === 1'b0);
		step();
		reset_values();
		write_transaction(5'h04, 16'h1234);
		read_transaction(5'h04, 16'h1234);
		read_transaction(5'h09, 16'hA509);
		illegal_opcode();
		interrupt_completion();
		write_while_busy();
		$display("Regression passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Watchdog timeout, the tests did not finish in time");
	end

endmodule

// ==== rtl/e1000_mdio_top.sv ====
`timescale 1ns/1ps

module e1000_mdio_top #(
	parameter int                   CLK_PERIOD_NS = 8,
	parameter int                   MDIO_FREQ     = 8000000,
	parameter e1000_pkg::phy_addr_t PHY_ADDR      = '0 // Used instead of the MDIC PHY field
) (
	input  logic        aclk,
	input  logic        rst_i,
	input  logic        reg_wr_i,
	input  logic        reg_rd_i,
	input  logic [31:0] reg_addr_i,
	input  logic [31:0] reg_wdata_i,
	output logic [31:0] reg_rdata_o,
	output logic        intr_o,
	output logic        phy_mdc_o,
	input  logic        phy_mdio_i,
	output logic        phy_mdio_o,
	output logic        phy_mdio_oe_o,
	output logic        phy_mdio_req_o,
	input  logic        phy_mdio_gnt_i
);

	localparam int MDC_DIV = (1000000000 / MDIO_FREQ) / CLK_PERIOD_NS + 1;

	mdio_cmd_if   u_cmd_if ();
	mdio_frame_if u_frame_if ();

	mdic_regs u_mdic_regs (
		.aclk        (aclk),
		.rst_i       (rst_i),
		.reg_wr_i    (reg_wr_i),
		.reg_rd_i    (reg_rd_i),
		.reg_addr_i  (reg_addr_i),
		.reg_wdata_i (reg_wdata_i),
		.reg_rdata_o (reg_rdata_o),
		.intr_o      (intr_o),
		.cmd         (u_cmd_if.src)
	);

	mdio_framer #(.PHY_ADDR(PHY_ADDR)) u_mdio_framer (
		.aclk  (aclk),
		.rst_i (rst_i),
		.cmd   (u_cmd_if.snk),
		.frm   (u_frame_if.src)
	);

	mdio_shifter #(.MDC_DIV(MDC_DIV)) u_mdio_shifter (
		.aclk           (aclk),
		.rst_i          (rst_i),
		.frm            (u_frame_if.snk),
		.phy_mdc_o      (phy_mdc_o),
		.phy_mdio_i     (phy_mdio_i),
		.phy_mdio_o     (phy_mdio_o),
		.phy_mdio_oe_o  (phy_mdio_oe_o),
		.phy_mdio_req_o (phy_mdio_req_o),
		.phy_mdio_gnt_i (phy_mdio_gnt_i)
	);

endmodule

// ==== rtl/e1000_pkg.sv ====
package e1000_pkg;

	// Byte address of the 32-bit MDIC register
	localparam logic [31:0] MDIC_OFFSET = 32'h0000_0020;

	localparam int MDIC_DATA_LSB  = 0;
	localparam int MDIC_REGAD_LSB = 16;
	localparam int MDIC_PHYAD_LSB = 21;
	localparam int MDIC_OP_LSB    = 26;

	localparam int MDIC_R_BIT = 28; // Ready
	localparam int MDIC_I_BIT = 29; // Interrupt enable
	localparam int MDIC_E_BIT = 30; // Error

	// Clause 22 opcodes where 00 and 11 are rejected
	typedef enum logic [1:0] {
		MDIO_OP_RSVD0 = 2'b00,
		MDIO_OP_WR    = 2'b01,
		MDIO_OP_RD    = 2'b10,
		MDIO_OP_RSVD3 = 2'b11
	} mdio_op_e;

	typedef logic [4:0]  phy_addr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] mdio_data_t;

	// ST, OP, PHYAD, REGAD, TA, DATA from MSB down
	typedef logic [31:0] mdio_frame_t;

	localparam logic [1:0] MDIO_START = 2'b01;
	localparam logic [1:0] MDIO_TA    = 2'b10;

	localparam int PREAMBLE_BITS = 32;

	// Frame bit where the PHY takes over on reads
	localparam int TA_BIT_INDEX = 14;

endpackage

// ==== rtl/mdic_regs.sv ====
`timescale 1ns/1ps

module mdic_regs (
	input  logic        aclk,
	input  logic        rst_i,
	input  logic        reg_wr_i,
	input  logic        reg_rd_i,
	input  logic [31:0] reg_addr_i,
	input  logic [31:0] reg_wdata_i,
	output logic [31:0] reg_rdata_o,
	output logic        intr_o,
	mdio_cmd_if.src     cmd
);

	e1000_pkg::mdio_data_t data_q;
	e1000_pkg::reg_addr_t  regad_q;
	e1000_pkg::phy_addr_t  phyad_q;
	e1000_pkg::mdio_op_e   op_q;
	logic                  r_q;
	logic                  i_q;
	logic                  e_q;
	logic                  cmd_valid_q;
	logic [31:0]           mdic;
	logic                  hit;
	logic                  wr_accept;

	assign hit = (reg_addr_i == e1000_pkg::MDIC_OFFSET);

	// Writes are dropped while a command is pending or in flight
	assign wr_accept = reg_wr_i && hit && cmd.cmd_ready && !cmd_valid_q;

	always_comb begin
		mdic = '0;
		mdic[e1000_pkg::MDIC_DATA_LSB +: $bits(e1000_pkg::mdio_data_t)] = data_q;
		mdic[e1000_pkg::MDIC_REGAD_LSB +: $bits(e1000_pkg::reg_addr_t)] = regad_q;
		mdic[e1000_pkg::MDIC_PHYAD_LSB +: $bits(e1000_pkg::phy_addr_t)] = phyad_q;
		mdic[e1000_pkg::MDIC_OP_LSB +: $bits(e1000_pkg::mdio_op_e)]     = op_q;
		mdic[e1000_pkg::MDIC_R_BIT] = r_q;
		mdic[e1000_pkg::MDIC_I_BIT] = i_q;
		mdic[e1000_pkg::MDIC_E_BIT] = e_q;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			data_q      <= '0;
			regad_q     <= '0;
			phyad_q     <= '0;
			op_q        <= e1000_pkg::MDIO_OP_RSVD0;
			r_q         <= 1'b0;
			i_q         <= 1'b0;
			e_q         <= 1'b0;
			cmd_valid_q <= 1'b0;
			intr_o      <= 1'b0;
		end else begin
			if (wr_accept) begin
				data_q  <= e1000_pkg::mdio_data_t'(reg_wdata_i >> e1000_pkg::MDIC_DATA_LSB);
				regad_q <= e1000_pkg::reg_addr_t'(reg_wdata_i >> e1000_pkg::MDIC_REGAD_LSB);
				phyad_q <= e1000_pkg::phy_addr_t'(reg_wdata_i >> e1000_pkg::MDIC_PHYAD_LSB);
				op_q    <= e1000_pkg::mdio_op_e'(reg_wdata_i[e1000_pkg::MDIC_OP_LSB +: 2]);
				i_q     <= reg_wdata_i[e1000_pkg::MDIC_I_BIT];
				r_q     <= 1'b0;
				e_q     <= 1'b0;
			end

			if (wr_accept)
				cmd_valid_q <= 1'b1;
			else if (cmd_valid_q && cmd.cmd_ready)
				cmd_valid_q <= 1'b0;

			if (reg_rd_i && hit)
				intr_o <= 1'b0; // Read to clear

			// Completion wins over a same-cycle clear
			if (cmd.done) begin
				r_q <= 1'b1;
				e_q <= cmd.error;
				if (op_q == e1000_pkg::MDIO_OP_RD && !cmd.error)
					data_q <= cmd.rdata;
				if (i_q)
					intr_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (reg_rd_i)
			reg_rdata_o <= hit ? mdic : 32'h0;
	end

	assign cmd.cmd_valid = cmd_valid_q;
	assign cmd.op        = op_q;
	assign cmd.regad     = regad_q;
	assign cmd.wdata     = data_q;

endmodule

// ==== rtl/mdio_framer.sv ====
`timescale 1ns/1ps

module mdio_framer #(
	parameter e1000_pkg::phy_addr_t PHY_ADDR = '0
) (
	input  logic       aclk,
	input  logic       rst_i,
	mdio_cmd_if.snk    cmd,
	mdio_frame_if.src  frm
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_ERR,  // Reject illegal opcode
		F_SEND, // Frame offered to the shifter
		F_WAIT  // Frame on the wire
	} state_e;

	state_e                 state_q;
	e1000_pkg::mdio_frame_t frame_q;
	e1000_pkg::mdio_data_t  frame_data;
	e1000_pkg::mdio_data_t  rdata_q;
	logic                   is_read_q;
	logic                   done_q;
	logic                   error_q;
	logic                   legal;
	logic                   accept;

	assign legal  = (cmd.op == e1000_pkg::MDIO_OP_WR) || (cmd.op == e1000_pkg::MDIO_OP_RD);
	assign accept = cmd.cmd_valid && cmd.cmd_ready;

	// Reads put zeros in the data field
	assign frame_data = (cmd.op == e1000_pkg::MDIO_OP_RD) ? '0 : cmd.wdata;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			state_q <= F_IDLE;
			done_q  <= 1'b0;
			error_q <= 1'b0;
		end else begin
			done_q  <= 1'b0;
			error_q <= 1'b0;
			case (state_q)
				F_IDLE: if (accept) state_q <= legal ? F_SEND : F_ERR;
				F_ERR: begin
					done_q  <= 1'b1;
					error_q <= 1'b1;
					state_q <= F_IDLE;
				end
				F_SEND: if (frm.frm_ready) state_q <= F_WAIT;
				F_WAIT: begin
					if (frm.done) begin
						done_q  <= 1'b1;
						state_q <= F_IDLE;
					end
				end
				default: state_q <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			frame_q <= {e1000_pkg::MDIO_START, cmd.op, PHY_ADDR, cmd.regad,
				e1000_pkg::MDIO_TA, frame_data};
			is_read_q <= (cmd.op == e1000_pkg::MDIO_OP_RD);
		end
		if (frm.done)
			rdata_q <= frm.rdata;
	end

	// Hold off the register while the done pulse is still out
	assign cmd.cmd_ready = (state_q == F_IDLE) && !done_q;
	assign cmd.done      = done_q;
	assign cmd.error     = error_q;
	assign cmd.rdata     = rdata_q;

	assign frm.frm_valid = (state_q == F_SEND);
	assign frm.frame     = frame_q;
	assign frm.is_read   = is_read_q;

endmodule

// ==== rtl/mdio_if.sv ====
`timescale 1ns/1ps

// Command from the MDIC register to the framer
interface mdio_cmd_if;
	logic                   cmd_valid;
	e1000_pkg::mdio_op_e    op;
	e1000_pkg::reg_addr_t   regad;
	e1000_pkg::mdio_data_t  wdata;
	logic                   cmd_ready;
	logic                   done; // One-cycle pulse
	logic                   error;
	e1000_pkg::mdio_data_t  rdata;

	modport src (
		output cmd_valid, op, regad, wdata,
		input  cmd_ready, done, error, rdata
	);

	modport snk (
		input  cmd_valid, op, regad, wdata,
		output cmd_ready, done, error, rdata
	);
endinterface

// Assembled frame from the framer to the serial shifter
interface mdio_frame_if;
	logic                   frm_valid;
	e1000_pkg::mdio_frame_t frame;
	logic                   is_read;
	logic                   frm_ready;
	logic                   done;
	e1000_pkg::mdio_data_t  rdata;

	modport src (
		output frm_valid, frame, is_read,
		input  frm_ready, done, rdata
	);

	modport snk (
		input  frm_valid, frame, is_read,
		output frm_ready, done, rdata
	);
endinterface

// ==== rtl/mdio_shifter.sv ====
`timescale 1ns/1ps

module mdio_shifter #(
	parameter int MDC_DIV = 5 // aclk cycles per MDC half period
) (
	input  logic      aclk,
	input  logic      rst_i,
	mdio_frame_if.snk frm,
	output logic      phy_mdc_o,
	input  logic      phy_mdio_i,
	output logic      phy_mdio_o,
	output logic      phy_mdio_oe_o,
	output logic      phy_mdio_req_o,
	input  logic      phy_mdio_gnt_i
);

	localparam int FRAME_BITS = $bits(e1000_pkg::mdio_frame_t);
	localparam int TOTAL_BITS = e1000_pkg::PREAMBLE_BITS + FRAME_BITS;
	localparam int TA_FIRST   = e1000_pkg::PREAMBLE_BITS + e1000_pkg::TA_BIT_INDEX;
	localparam int DATA_FIRST = TOTAL_BITS - $bits(e1000_pkg::mdio_data_t);
	localparam int CNT_W      = $clog2(MDC_DIV + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_SHIFT
	} state_e;

	state_e                state_q;
	logic [CNT_W-1:0]      half_cnt;
	logic [5:0]            bit_cnt;
	logic [TOTAL_BITS-1:0] sreg;
	logic                  mdc_q;
	logic                  oe_q;
	logic                  req_q;
	logic                  done_q;
	logic                  is_read_q;
	e1000_pkg::mdio_data_t rdata_q;
	logic                  half_end;
	logic                  last_bit;
	logic                  sample_en;

	assign half_end = (half_cnt == CNT_W'(MDC_DIV - 1));
	assign last_bit = (bit_cnt == 6'(TOTAL_BITS - 1));

	// Read data is taken as MDC rises
	assign sample_en = (state_q == S_SHIFT) && half_end && !mdc_q && is_read_q &&
		(bit_cnt >= 6'(DATA_FIRST));

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			state_q  <= S_IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
			sreg     <= '1; // MDIO idles high
			mdc_q    <= 1'b0;
			oe_q     <= 1'b0;
			req_q    <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (frm.frm_valid) begin
						sreg    <= {{e1000_pkg::PREAMBLE_BITS{1'b1}}, frm.frame};
						req_q   <= 1'b1;
						state_q <= S_REQ;
					end
				end
				S_REQ: begin
					if (phy_mdio_gnt_i) begin
						oe_q     <= 1'b1;
						half_cnt <= '0;
						bit_cnt  <= '0;
						state_q  <= S_SHIFT;
					end
				end
				S_SHIFT: begin
					if (!half_end) begin
						half_cnt <= half_cnt + 1'b1;
					end else begin
						half_cnt <= '0;
						mdc_q    <= !mdc_q;
						if (mdc_q) begin
							// Next bit goes out on the falling edge
							sreg <= {sreg[TOTAL_BITS-2:0], 1'b1};
							if (last_bit) begin
								req_q   <= 1'b0;
								oe_q    <= 1'b0;
								done_q  <= 1'b1;
								state_q <= S_IDLE;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								oe_q    <= !(is_read_q && (bit_cnt + 6'd1 >= 6'(TA_FIRST)));
							end
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state_q == S_IDLE && frm.frm_valid)
			is_read_q <= frm.is_read;
		if (sample_en)
			rdata_q <= {rdata_q[$bits(e1000_pkg::mdio_data_t)-2:0], phy_mdio_i};
	end

	assign phy_mdc_o      = mdc_q;
	assign phy_mdio_o     = sreg[TOTAL_BITS-1];
	assign phy_mdio_oe_o  = oe_q;
	assign phy_mdio_req_o = req_q;

	assign frm.frm_ready = (state_q == S_IDLE);
	assign frm.done      = done_q;
	assign frm.rdata     = rdata_q;

endmodule

// ==== sim.f ====
rtl/e1000_pkg.sv
rtl/mdio_if.sv
rtl/mdic_regs.sv
rtl/mdio_framer.sv
rtl/mdio_shifter.sv
rtl/e1000_mdio_top.sv
bench/tb_clkgen.sv
bench/tb_phy_model.sv
bench/tb_top.sv
